/* rtl/nco_cfg_pkg.sv */
package nco_cfg_pkg;

    // Phase accumulator
    localparam int PHASE_W = 32;

    // Table lookup, addressed by the top phase bits
    localparam int LUT_ADDR_W = 6;
    localparam int LUT_DEPTH = 1 << LUT_ADDR_W;

    // Signed output samples
    localparam int SAMPLE_W = 16;

    // Attenuation as arithmetic right shift, 0 to 7
    localparam int SHIFT_W = 3;

endpackage : nco_cfg_pkg

/* rtl/nco_cmd_pkg.sv */
package nco_cmd_pkg;

    localparam int CMD_DATA_W = 32;

    typedef enum logic [1:0] {
        CMD_NOP       = 2'd0,
        CMD_SET_INC   = 2'd1,
        CMD_SET_SHIFT = 2'd2,
        CMD_SYNC      = 2'd3
    } cmd_op_t;

endpackage : nco_cmd_pkg

/* rtl/nco_ctrl_if.sv */
`timescale 1ns/1ps

interface nco_ctrl_if;
    import nco_cfg_pkg::*;

    logic [PHASE_W-1:0] phase_inc;
    logic [SHIFT_W-1:0] shift;
    // One-cycle pulse after every command
    logic               restart;
    logic               running;

    modport decode_mp (output phase_inc, output shift, output restart, output running);
    modport dp_mp (input phase_inc, input shift, input restart, input running);

endinterface : nco_ctrl_if

/* rtl/nco_lane_if.sv */
`timescale 1ns/1ps

interface nco_lane_if;
    import nco_cfg_pkg::*;

    // Lane 0 at phase p, lane 1 at p plus one increment
    logic signed [SAMPLE_W-1:0] sine0;
    logic signed [SAMPLE_W-1:0] cosine0;
    logic signed [SAMPLE_W-1:0] sine1;
    logic signed [SAMPLE_W-1:0] cosine1;
    logic                       valid;

    modport src_mp (output sine0, output cosine0, output sine1, output cosine1,
                    output valid);
    modport dst_mp (input sine0, input cosine0, input sine1, input cosine1,
                    input valid);

endinterface : nco_lane_if

/* rtl/nco_cmd_decode.sv */
`timescale 1ns/1ps

module nco_cmd_decode (
    input  logic                                   i_clock,
    input  logic                                   i_rst_n,
    input  logic                                   i_cmd_valid,
    input  nco_cmd_pkg::cmd_op_t                   i_cmd_op,
    input  logic [nco_cmd_pkg::CMD_DATA_W-1:0]     i_cmd_data,
    nco_ctrl_if.decode_mp                          ctrl
);
    import nco_cfg_pkg::*;
    import nco_cmd_pkg::*;

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            ctrl.phase_inc <= '0;
            ctrl.shift     <= '0;
            ctrl.restart   <= 1'b0;
            ctrl.running   <= 1'b0;
        end else begin
            // Every command restarts the stream, NOP included
            ctrl.restart <= i_cmd_valid;
            if (i_cmd_valid) begin
                ctrl.running <= 1'b1;
                case (i_cmd_op)
                    CMD_SET_INC: begin
                        ctrl.phase_inc <= i_cmd_data[PHASE_W-1:0];
                    end
                    CMD_SET_SHIFT: begin
                        ctrl.shift <= i_cmd_data[SHIFT_W-1:0];
                    end
                    CMD_SYNC: begin
                        // Settings kept, restart only
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Commands must be spaced at least two cycles apart
    a_restart_single: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        ctrl.restart |=> !ctrl.restart
    ) else $error("restart held for two consecutive cycles");

endmodule : nco_cmd_decode

/* rtl/nco_phase_accum.sv */
`timescale 1ns/1ps

module nco_phase_accum (
    input  logic                                i_clock,
    input  logic                                i_rst_n,
    input  logic                                i_ready,
    nco_ctrl_if.dp_mp                           ctrl,
    output logic [nco_cfg_pkg::LUT_ADDR_W-1:0]  o_addr0,
    output logic [nco_cfg_pkg::LUT_ADDR_W-1:0]  o_addr1,
    output logic                                o_addr_valid
);
    import nco_cfg_pkg::*;

    logic [PHASE_W-1:0] phase0;
    logic [PHASE_W-1:0] phase1;
    logic [PHASE_W-1:0] step;

    // Two samples per clock, so both lanes move by twice the increment
    assign step = ctrl.phase_inc << 1;

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            phase0       <= '0;
            phase1       <= '0;
            o_addr_valid <= 1'b0;
        end else if (ctrl.restart) begin
            phase0       <= '0;
            phase1       <= ctrl.phase_inc;
            o_addr_valid <= 1'b1;
        end else if (i_ready && ctrl.running) begin
            phase0 <= phase0 + step;
            phase1 <= phase1 + step;
        end
    end

    assign o_addr0 = phase0[PHASE_W-1 -: LUT_ADDR_W];
    assign o_addr1 = phase1[PHASE_W-1 -: LUT_ADDR_W];

    // Lane spacing follows the increment once the reload has happened
    a_lane_spacing: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        $stable(ctrl.phase_inc) |-> (phase1 - phase0 == ctrl.phase_inc)
    ) else $error("lane 1 is not one increment ahead of lane 0");

endmodule : nco_phase_accum

/* rtl/nco_sincos_rom.sv */
`timescale 1ns/1ps

module nco_sincos_rom (
    input  logic                                i_clock,
    input  logic                                i_rst_n,
    input  logic                                i_ready,
    input  logic                                i_restart,
    input  logic [nco_cfg_pkg::LUT_ADDR_W-1:0]  i_addr0,
    input  logic [nco_cfg_pkg::LUT_ADDR_W-1:0]  i_addr1,
    input  logic                                i_addr_valid,
    nco_lane_if.src_mp                          lane
);
    import nco_cfg_pkg::*;

    // Sine in the upper half, cosine in the lower half
    logic [2*SAMPLE_W-1:0] lut_mem [LUT_DEPTH];
    logic [2*SAMPLE_W-1:0] word0;
    logic [2*SAMPLE_W-1:0] word1;

    initial begin
        $readmemh("sincos.mem", lut_mem);
    end

    always_ff @(posedge i_clock) begin
        if (i_ready) begin
            word0 <= lut_mem[i_addr0];
            word1 <= lut_mem[i_addr1];
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n || i_restart) begin
            lane.valid <= 1'b0;
        end else if (i_ready) begin
            lane.valid <= i_addr_valid;
        end
    end

    assign lane.sine0   = word0[2*SAMPLE_W-1:SAMPLE_W];
    assign lane.cosine0 = word0[SAMPLE_W-1:0];
    assign lane.sine1   = word1[2*SAMPLE_W-1:SAMPLE_W];
    assign lane.cosine1 = word1[SAMPLE_W-1:0];

endmodule : nco_sincos_rom

/* rtl/nco_output_stage.sv */
`timescale 1ns/1ps

module nco_output_stage (
    input  logic        i_clock,
    input  logic        i_rst_n,
    input  logic        i_ready,
    nco_ctrl_if.dp_mp   ctrl,
    nco_lane_if.dst_mp  lane_in,
    nco_lane_if.src_mp  lane_out
);
    import nco_cfg_pkg::*;

    logic signed [SAMPLE_W-1:0] sine0_q;
    logic signed [SAMPLE_W-1:0] cosine0_q;
    logic signed [SAMPLE_W-1:0] sine1_q;
    logic signed [SAMPLE_W-1:0] cosine1_q;
    logic                       scaled_valid;

    // Stage one, attenuation
    always_ff @(posedge i_clock) begin
        if (i_ready) begin
            sine0_q   <= lane_in.sine0 >>> ctrl.shift;
            cosine0_q <= lane_in.cosine0 >>> ctrl.shift;
            sine1_q   <= lane_in.sine1 >>> ctrl.shift;
            cosine1_q <= lane_in.cosine1 >>> ctrl.shift;
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n || ctrl.restart) begin
            scaled_valid <= 1'b0;
        end else if (i_ready) begin
            scaled_valid <= lane_in.valid;
        end
    end

    // Stage two, output register
    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            lane_out.sine0   <= '0;
            lane_out.cosine0 <= '0;
            lane_out.sine1   <= '0;
            lane_out.cosine1 <= '0;
            lane_out.valid   <= 1'b0;
        end else begin
            if (ctrl.restart) begin
                lane_out.valid <= 1'b0;
            end else if (i_ready) begin
                lane_out.valid <= scaled_valid;
            end
            if (i_ready) begin
                lane_out.sine0   <= sine0_q;
                lane_out.cosine0 <= cosine0_q;
                lane_out.sine1   <= sine1_q;
                lane_out.cosine1 <= cosine1_q;
            end
        end
    end

    // A pair offered but not taken must not change
    a_stall_stable: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        (lane_out.valid && !i_ready) |=> $stable({lane_out.sine0, lane_out.cosine0,
                                                  lane_out.sine1, lane_out.cosine1})
    ) else $error("output pair changed while stalled");

endmodule : nco_output_stage

/* rtl/nco2x_top.sv */
`timescale 1ns/1ps

module nco2x_top (
    input  logic                                    i_clock,
    input  logic                                    i_rst_n,
    input  logic                                    i_cmd_valid,
    input  logic [1:0]                              i_cmd_op,
    input  logic [nco_cmd_pkg::CMD_DATA_W-1:0]      i_cmd_data,
    input  logic                                    i_ready,
    output logic                                    o_valid,
    output logic signed [nco_cfg_pkg::SAMPLE_W-1:0] o_sine0,
    output logic signed [nco_cfg_pkg::SAMPLE_W-1:0] o_cosine0,
    output logic signed [nco_cfg_pkg::SAMPLE_W-1:0] o_sine1,
    output logic signed [nco_cfg_pkg::SAMPLE_W-1:0] o_cosine1
);
    import nco_cfg_pkg::*;
    import nco_cmd_pkg::*;

    cmd_op_t               cmd_op;
    logic [LUT_ADDR_W-1:0] addr0;
    logic [LUT_ADDR_W-1:0] addr1;
    logic                  addr_valid;

    nco_ctrl_if ctrl ();
    nco_lane_if lane_rom ();
    nco_lane_if lane_out ();

    assign cmd_op = cmd_op_t'(i_cmd_op);

    nco_cmd_decode u_nco_cmd_decode (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_cmd_valid (i_cmd_valid),
        .i_cmd_op    (cmd_op),
        .i_cmd_data  (i_cmd_data),
        .ctrl        (ctrl)
    );

    nco_phase_accum u_nco_phase_accum (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_ready      (i_ready),
        .ctrl         (ctrl),
        .o_addr0      (addr0),
        .o_addr1      (addr1),
        .o_addr_valid (addr_valid)
    );

    nco_sincos_rom u_nco_sincos_rom (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_ready      (i_ready),
        .i_restart    (ctrl.restart),
        .i_addr0      (addr0),
        .i_addr1      (addr1),
        .i_addr_valid (addr_valid),
        .lane         (lane_rom)
    );

    nco_output_stage u_nco_output_stage (
        .i_clock  (i_clock),
        .i_rst_n  (i_rst_n),
        .i_ready  (i_ready),
        .ctrl     (ctrl),
        .lane_in  (lane_rom),
        .lane_out (lane_out)
    );

    assign o_valid   = lane_out.valid;
    assign o_sine0   = lane_out.sine0;
    assign o_cosine0 = lane_out.cosine0;
    assign o_sine1   = lane_out.sine1;
    assign o_cosine1 = lane_out.cosine1;

endmodule : nco2x_top

/* verification/nco2x_tb.sv */
`timescale 1ns/1ps

module nco2x_tb;
    import nco_cfg_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 10;
    // Command port opcodes
    localparam logic [1:0] OP_SET_INC = 2'd1;
    localparam logic [1:0] OP_SET_SHIFT = 2'd2;
    localparam logic [1:0] OP_SYNC = 2'd3;
    localparam int TOTAL_PAIRS = 8 + 64 + 3 * 32 + 200 + 3 * 16;
    localparam int TIMEOUT_CYCLES = TOTAL_PAIRS * 4 + 100;

    logic                       i_clock;
    logic                       i_rst_n;
    logic                       i_cmd_valid;
    logic [1:0]                 i_cmd_op;
    logic [31:0]                i_cmd_data;
    logic                       i_ready;
    logic                       o_valid;
    logic signed [SAMPLE_W-1:0] o_sine0;
    logic signed [SAMPLE_W-1:0] o_cosine0;
    logic signed [SAMPLE_W-1:0] o_sine1;
    logic signed [SAMPLE_W-1:0] o_cosine1;

    logic [2*SAMPLE_W-1:0] table_mem [LUT_DEPTH];
    logic [31:0]           model_inc = '0;
    logic [2:0]            model_shift = '0;
    int unsigned           model_n = 0;
    int                    pair_count = 0;
    int                    err_count = 0;
    int                    test_errs = 0;
    int                    tests_passed = 0;
    int                    tests_failed = 0;
    int                    seed = 32'hb7ff;
    int                    rnd;
    int                    latency;
    string                 test_name = "reset";
    logic                  stalled = 1'b0;
    logic [4*SAMPLE_W-1:0] held_pair = '0;

    nco2x_top u_nco2x_top (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_cmd_valid (i_cmd_valid),
        .i_cmd_op    (i_cmd_op),
        .i_cmd_data  (i_cmd_data),
        .i_ready     (i_ready),
        .o_valid     (o_valid),
        .o_sine0     (o_sine0),
        .o_cosine0   (o_cosine0),
        .o_sine1     (o_sine1),
        .o_cosine1   (o_cosine1)
    );

    always #(CLK_PERIOD / 2) i_clock = ~i_clock;

    // Lane 0 at n times the increment, lane 1 one increment later
    function automatic logic [4*SAMPLE_W-1:0] ref_pair(input int unsigned n,
                                                      input logic [31:0] inc,
                                                      input logic [2:0] shift);
        logic [31:0]                ph0;
        logic [31:0]                ph1;
        logic [2*SAMPLE_W-1:0]      w0;
        logic [2*SAMPLE_W-1:0]      w1;
        logic signed [SAMPLE_W-1:0] s0;
        logic signed [SAMPLE_W-1:0] c0;
        logic signed [SAMPLE_W-1:0] s1;
        logic signed [SAMPLE_W-1:0] c1;
        ph0 = n * inc;
        ph1 = (n + 1) * inc;
        w0 = table_mem[ph0[31:26]];
        w1 = table_mem[ph1[31:26]];
        s0 = w0[31:16];
        c0 = w0[15:0];
        s1 = w1[31:16];
        c1 = w1[15:0];
        return {s0 >>> shift, c0 >>> shift, s1 >>> shift, c1 >>> shift};
    endfunction

    task automatic check_sample(input string field, input logic [SAMPLE_W-1:0] exp_val,
                                input logic [SAMPLE_W-1:0] act_val);
        assert (act_val == exp_val) else begin
            $display("error %s %s pair %0d expected %0d actual %0d", test_name, field,
                     pair_count, $signed(exp_val), $signed(act_val));
            err_count++;
            test_errs++;
        end
    endtask

    always @(posedge i_clock) begin : compare_outputs
        logic [4*SAMPLE_W-1:0] expected;
        logic [4*SAMPLE_W-1:0] actual;
        actual = {o_sine0, o_cosine0, o_sine1, o_cosine1};
        if (stalled) begin
            assert (actual == held_pair) else begin
                $display("%s: output pair changed while the pipeline was stalled", test_name);
                err_count++;
                test_errs++;
            end
        end
        stalled = i_rst_n && o_valid && !i_ready;
        held_pair = actual;
        if (i_rst_n && o_valid && i_ready) begin
            expected = ref_pair(model_n, model_inc, model_shift);
            check_sample("sine0", expected[63:48], o_sine0);
            check_sample("cosine0", expected[47:32], o_cosine0);
            check_sample("sine1", expected[31:16], o_sine1);
            check_sample("cosine1", expected[15:0], o_cosine1);
            model_n = model_n + 2;
            pair_count = pair_count + 1;
        end
    end

    // Strobe for one cycle, then restart the model once the old stream has left
    task automatic issue_cmd(input logic [1:0] op, input logic [31:0] data);
        @(negedge i_clock);
        i_cmd_valid = 1'b1;
        i_cmd_op = op;
        i_cmd_data = data;
        @(negedge i_clock);
        i_cmd_valid = 1'b0;
        @(negedge i_clock);
        if (op == OP_SET_INC) begin
            model_inc = data;
        end else if (op == OP_SET_SHIFT) begin
            model_shift = data[2:0];
        end
        model_n = 0;
        pair_count = 0;
    endtask

    task automatic wait_pairs(input int count);
        while (pair_count < count) begin
            @(negedge i_clock);
        end
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("test %s done: %0d pairs, %0d errors", test_name, pair_count, test_errs);
        test_errs = 0;
    endtask

    task automatic run_shift_test(input logic [2:0] shift_val);
        test_name = $sformatf("set_shift_%0d", shift_val);
        issue_cmd(OP_SET_SHIFT, {29'd0, shift_val});
        wait_pairs(32);
        finish_test();
    endtask

    initial begin : watchdog
        #((RESET_CYCLES + TIMEOUT_CYCLES) * CLK_PERIOD);
        $display("timeout: test %s did not finish in time", test_name);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        i_clock = 1'b0;
        i_rst_n = 1'b0;
        i_cmd_valid = 1'b0;
        i_cmd_op = 2'd0;
        i_cmd_data = '0;
        i_ready = 1'b1;
        $readmemh("sincos.mem", table_mem);
        repeat (RESET_CYCLES) @(negedge i_clock);
        i_rst_n = 1'b1;

        test_name = "reset_latency";
        repeat (5) begin
            @(negedge i_clock);
            assert (!o_valid) else begin
                $display("%s: o_valid went high before any command", test_name);
                err_count++;
                test_errs++;
            end
        end
        issue_cmd(OP_SET_INC, 32'h0400_0000);
        latency = 1;
        while (!o_valid && latency < 10) begin
            @(negedge i_clock);
            latency++;
        end
        assert (latency == 4) else begin
            $display("error %s latency expected %0d actual %0d", test_name, 4, latency);
            err_count++;
            test_errs++;
        end
        wait_pairs(8);
        finish_test();

        // Enough pairs for the phase to wrap
        test_name = "set_inc_wrap";
        issue_cmd(OP_SET_INC, 32'h0312_4dd3);
        wait_pairs(64);
        finish_test();

        run_shift_test(3'd0);
        run_shift_test(3'd3);
        run_shift_test(3'd7);

        test_name = "backpressure";
        issue_cmd(OP_SET_SHIFT, 32'd1);
        while (pair_count < 200) begin
            @(negedge i_clock);
            rnd = $random(seed);
            i_ready = rnd[0];
        end
        @(negedge i_clock);
        i_ready = 1'b1;
        finish_test();

        test_name = "sync_mid_stream";
        issue_cmd(OP_SET_INC, 32'h0a3d_70a4);
        wait_pairs(16);
        issue_cmd(OP_SYNC, 32'd0);
        wait_pairs(16);
        finish_test();

        test_name = "inc_mid_stream";
        issue_cmd(OP_SET_INC, 32'h01b5_c2e9);
        wait_pairs(16);
        finish_test();

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
                 err_count);
        if (err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : nco2x_tb

/* nco2x.f */
rtl/nco_cfg_pkg.sv
rtl/nco_cmd_pkg.sv
rtl/nco_ctrl_if.sv
rtl/nco_lane_if.sv
rtl/nco_cmd_decode.sv
rtl/nco_phase_accum.sv
rtl/nco_sincos_rom.sv
rtl/nco_output_stage.sv
rtl/nco2x_top.sv
verification/nco2x_tb.sv

/* Makefile */
TOP := nco2x_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f nco2x.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* sincos.mem */
// One word per table entry: sine [31:16], cosine [15:0], both signed 16-bit
00007FFF
0C8C7F61
18F97D89
25287A7C
30FB7641
3C5670E2
471C6A6D
513362F1
5A825A82
62F15133
6A6D471C
70E23C56
764130FB
7A7C2528
7D8918F9
7F610C8C
7FFF0000
7F61F374
7D89E707
7A7CDAD8
7641CF05
70E2C3AA
6A6DB8E4
62F1AECD
5A82A57E
51339D0F
471C9593
3C568F1E
30FB89BF
25288584
18F98277
0C8C809F
00008001
F374809F
E7078277
DAD88584
CF0589BF
C3AA8F1E
B8E49593
AECD9D0F
A57EA57E
9D0FAECD
9593B8E4
8F1EC3AA
89BFCF05
8584DAD8
8277E707
809FF374
80010000
809F0C8C
827718F9
85842528
89BF30FB
8F1E3C56
9593471C
9D0F5133
A57E5A82
AECD62F1
B8E46A6D
C3AA70E2
CF057641
DAD87A7C
E7077D89
F3747F61
